// ==== Bender.yml ====
package:
  name: hires_scan

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - scan_pkg.sv
      - scan_timing_decode.sv
      - scan_raster_counter.sv
      - scan_line_ram.sv
      - scan_line_doubler.sv
      - hires_scan_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_hires_scan.sv

// ==== files.f ====
+incdir+.
scan_pkg.sv
scan_timing_decode.sv
scan_raster_counter.sv
scan_line_ram.sv
scan_line_doubler.sv
hires_scan_top.sv
tb_hires_scan.sv

// ==== hires_scan_top.sv ====
`timescale 1ns/1ps

`include "scan_defs.svh"

// scan doubler top, geometry decode feeding the raster counter and line store
module hires_scan_top (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  scan_pkg::chip_t      chip,
    input  logic                 is_15khz,
    input  logic [`SCAN_RXW-1:0] raster_x,
    input  scan_pkg::hpos_t      hires_raster_x,
    input  logic [`SCAN_RYW-1:0] raster_y,
    input  scan_pkg::color_t     pixel_color3,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 active,
    output scan_pkg::color_t     pixel_color4,
    output logic                 half_bright
);

    // latched geometry
    scan_pkg::hpos_t max_width;
    scan_pkg::hpos_t hs_sta;
    scan_pkg::hpos_t hs_end;
    scan_pkg::hpos_t ha_sta;
    scan_pkg::hpos_t hoffset;
    scan_pkg::vpos_t max_height;
    scan_pkg::vpos_t vs_sta;
    scan_pkg::vpos_t vs_end;
    scan_pkg::vpos_t va_end;
    scan_pkg::vpos_t voffset;

    scan_pkg::hpos_t h_count;  // shared output x

    scan_timing_decode u_decode (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .chip       (chip),
        .is_15khz   (is_15khz),
        .max_width  (max_width),
        .hs_sta     (hs_sta),
        .hs_end     (hs_end),
        .ha_sta     (ha_sta),
        .hoffset    (hoffset),
        .max_height (max_height),
        .vs_sta     (vs_sta),
        .vs_end     (vs_end),
        .va_end     (va_end),
        .voffset    (voffset)
    );

    scan_raster_counter u_counter (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .is_15khz    (is_15khz),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .max_width   (max_width),
        .max_height  (max_height),
        .hs_sta      (hs_sta),
        .hs_end      (hs_end),
        .ha_sta      (ha_sta),
        .vs_sta      (vs_sta),
        .vs_end      (vs_end),
        .va_end      (va_end),
        .voffset     (voffset),
        .h_count     (h_count),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active),
        .half_bright (half_bright)
    );

    scan_line_doubler u_doubler (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .h_count        (h_count),
        .hoffset        (hoffset),
        .raster_x       (raster_x),
        .hires_raster_x (hires_raster_x),
        .pixel_color3   (pixel_color3),
        .pixel_color4   (pixel_color4)
    );

endmodule

// ==== scan_defs.svh ====
`ifndef SCAN_DEFS_SVH
`define SCAN_DEFS_SVH

// chip codes as strapped on the board
`define SCAN_CHIP_6567R56A 2'd0  // early ntsc part, 64 cycles per line
`define SCAN_CHIP_6567R8   2'd1  // later ntsc part, 65 cycles per line
`define SCAN_CHIP_6569R1   2'd2  // pal, first revision
`define SCAN_CHIP_6569R5   2'd3  // pal, same timing as r1

// output counters run at the doubled rate
`define SCAN_HW  11  // output x, covers widths up to 2047
`define SCAN_VW  10  // output y, covers 31 khz frames

// native raster coming from the video chip
`define SCAN_RXW 10  // native raster_x
`define SCAN_RYW 9   // native raster_y

// colour index, palette lookup happens downstream
`define SCAN_CW  4

`endif

// ==== scan_line_doubler.sv ====
`timescale 1ns/1ps

`include "scan_defs.svh"

// double buffered line store
// one buffer fills from the chip at hires_raster_x while the other
// is read back at h_count, buffers swap at each native line start
module scan_line_doubler (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  scan_pkg::hpos_t      h_count,         // output x from the counter
    input  scan_pkg::hpos_t      hoffset,         // read position shift
    input  logic [`SCAN_RXW-1:0] raster_x,        // native x, zero marks line start
    input  scan_pkg::hpos_t      hires_raster_x,  // write address
    input  scan_pkg::color_t     pixel_color3,    // incoming colour
    output scan_pkg::color_t     pixel_color4     // doubled colour out
);

    logic             active_buf;  // high writes buffer 0, reads buffer 1
    logic [3:0]       dot_phase;   // one hot, one native dot every four cycles
    scan_pkg::hpos_t  output_x;    // read address
    scan_pkg::hpos_t  addr0;
    scan_pkg::hpos_t  addr1;
    scan_pkg::color_t dout0;
    scan_pkg::color_t dout1;

    assign output_x = h_count - hoffset;

    // writer uses the chip position, reader the shifted output position
    assign addr0 = active_buf ? hires_raster_x : output_x;
    assign addr1 = active_buf ? output_x : hires_raster_x;

    scan_line_ram #(
        .depth_log2 (`SCAN_HW)
    ) u_buf0 (
        .clk_dot4x (clk_dot4x),
        .we        (active_buf),
        .addr      (addr0),
        .din       (pixel_color3),
        .dout      (dout0)
    );

    scan_line_ram #(
        .depth_log2 (`SCAN_HW)
    ) u_buf1 (
        .clk_dot4x (clk_dot4x),
        .we        (!active_buf),
        .addr      (addr1),
        .din       (pixel_color3),
        .dout      (dout1)
    );

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_phase    <= 4'b1000;
            active_buf   <= 1'b0;
            pixel_color4 <= '0;
        end else begin
            dot_phase <= {dot_phase[2:0], dot_phase[3]};  // rotate left

            // sample raster_x once per native dot
            if (dot_phase[1] && (raster_x == '0)) begin
                active_buf <= !active_buf;
            end

            // left of hoffset the address would wrap, keep the last colour
            if (h_count >= hoffset) begin
                pixel_color4 <= active_buf ? dout1 : dout0;
            end
        end
    end

endmodule

// ==== scan_line_ram.sv ====
`timescale 1ns/1ps

// one raster line of colour indices
// single port, read before write, registered output
module scan_line_ram #(
    parameter int depth_log2 = 11  // 2048 entries covers any doubled line
) (
    input  logic                  clk_dot4x,
    input  logic                  we,
    input  logic [depth_log2-1:0] addr,
    input  scan_pkg::color_t      din,
    output scan_pkg::color_t      dout
);

    (* ram_style = "block" *) scan_pkg::color_t mem [2**depth_log2];

    always_ff @(posedge clk_dot4x) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];  // old contents when writing
    end

endmodule

// ==== scan_pkg.sv ====
`include "scan_defs.svh"

package scan_pkg;

    // chip variant, selects the geometry table
    typedef enum logic [1:0] {
        CHIP_6567R56A = `SCAN_CHIP_6567R56A,
        CHIP_6567R8   = `SCAN_CHIP_6567R8,
        CHIP_6569R1   = `SCAN_CHIP_6569R1,
        CHIP_6569R5   = `SCAN_CHIP_6569R5
    } chip_t;

    // output x position, doubled horizontal resolution
    typedef logic [`SCAN_HW-1:0] hpos_t;

    // output y position, doubled line count at 31 khz
    typedef logic [`SCAN_VW-1:0] vpos_t;

    // colour index as stored in the line buffers
    typedef logic [`SCAN_CW-1:0] color_t;

endpackage

// ==== scan_raster_counter.sv ====
`timescale 1ns/1ps

`include "scan_defs.svh"

// output raster position, sync and active levels
// h_count runs at twice the native dot rate, every native line drawn twice
// at 31 khz, once at 15 khz where the counters step every other cycle
module scan_raster_counter (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  logic                 is_15khz,
    input  logic [`SCAN_RXW-1:0] raster_x,
    input  logic [`SCAN_RYW-1:0] raster_y,
    input  scan_pkg::hpos_t      max_width,
    input  scan_pkg::vpos_t      max_height,
    input  scan_pkg::hpos_t      hs_sta,
    input  scan_pkg::hpos_t      hs_end,
    input  scan_pkg::hpos_t      ha_sta,
    input  scan_pkg::vpos_t      vs_sta,
    input  scan_pkg::vpos_t      vs_end,
    input  scan_pkg::vpos_t      va_end,
    input  scan_pkg::vpos_t      voffset,
    output scan_pkg::hpos_t      h_count,      // output x, also the read position
    output logic                 hsync,        // active low
    output logic                 vsync,        // active low
    output logic                 active,
    output logic                 half_bright   // alternate output lines dimmed
);

    scan_pkg::vpos_t v_count;      // output y position
    scan_pkg::vpos_t v_start;      // v_count at frame start
    logic [1:0]      ff;           // dot phase within a native cycle
    logic            advance;      // counters step this cycle
    logic            line_end;     // last dot of the output line
    logic            frame_start;  // incoming frame begins

    // 31 khz steps every cycle, 15 khz only on odd phases
    assign advance = !is_15khz || ff[0];

    assign line_end    = (h_count >= max_width);
    assign frame_start = (raster_x == '0) && (raster_y == '0);

    // vertical count starts ahead so vsync lands before the visible area
    assign v_start = max_height - voffset;

    // sync pulses, low inside [sta, end)
    assign hsync = !((h_count >= hs_sta) && (h_count < hs_end));
    assign vsync = !((v_count >= vs_sta) && (v_count < vs_end));

    // visible area
    assign active = (h_count >= ha_sta) && (v_count < va_end);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ff          <= 2'd1;
            h_count     <= '0;
            v_count     <= v_start;  // geometry is valid after first reset cycle
            half_bright <= 1'b0;
        end else begin
            ff <= ff + 2'd1;  // free running

            if (advance) begin
                if (!line_end) begin
                    h_count <= h_count + 1'b1;
                end else begin
                    h_count <= '0;
                    if (v_count < max_height) begin
                        v_count     <= v_count + 1'b1;
                        half_bright <= !half_bright;  // every other line dim
                    end else begin
                        v_count     <= '0;
                        half_bright <= 1'b0;  // frame starts on a bright line
                    end
                end
            end

            // lock to the chip's frame, wins over the advance above
            if (frame_start) begin
                v_count <= v_start;
            end
        end
    end

endmodule

// ==== scan_timing_decode.sv ====
`timescale 1ns/1ps

// frame geometry for the selected chip and line rate
// loaded while rst is high, held afterwards so a mode change needs a reset
module scan_timing_decode (
    input  logic              clk_dot4x,
    input  logic              rst,
    input  scan_pkg::chip_t   chip,
    input  logic              is_15khz,
    output scan_pkg::hpos_t   max_width,   // last h_count of a line
    output scan_pkg::hpos_t   hs_sta,      // hsync falls here
    output scan_pkg::hpos_t   hs_end,      // hsync rises here
    output scan_pkg::hpos_t   ha_sta,      // first active x
    output scan_pkg::hpos_t   hoffset,     // shift between h_count and buffer address
    output scan_pkg::vpos_t   max_height,  // last v_count of a frame
    output scan_pkg::vpos_t   vs_sta,      // vsync falls here
    output scan_pkg::vpos_t   vs_end,      // vsync rises here
    output scan_pkg::vpos_t   va_end,      // first blanked line
    output scan_pkg::vpos_t   voffset      // v_count lead at frame start
);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            case (chip)
                scan_pkg::CHIP_6569R1, scan_pkg::CHIP_6569R5: begin
                    // 1008 dots per doubled line
                    max_width <= 11'd1007;
                    hs_sta    <= 11'd20;   // back porch 20
                    hs_end    <= 11'd140;  // sync pulse 120
                    ha_sta    <= 11'd200;  // front porch 60
                    hoffset   <= 11'd10;
                    voffset   <= 10'd20;
                    if (is_15khz) begin
                        // 312 lines, porches 5 and 20, sync 2
                        max_height <= 10'd311;
                        va_end     <= 10'd285;
                        vs_sta     <= 10'd290;
                        vs_end     <= 10'd292;
                    end else begin
                        // 624 lines, porches 11 and 41, sync 3
                        max_height <= 10'd623;
                        va_end     <= 10'd569;
                        vs_sta     <= 10'd580;
                        vs_end     <= 10'd583;
                    end
                end
                scan_pkg::CHIP_6567R8: begin
                    // 1040 dots per doubled line
                    max_width <= 11'd1039;
                    hs_sta    <= 11'd20;
                    hs_end    <= 11'd144;  // sync pulse 124
                    ha_sta    <= 11'd206;  // front porch 62
                    hoffset   <= 11'd20;
                    voffset   <= 10'd52;
                    if (is_15khz) begin
                        max_height <= 10'd262;  // 263 lines
                        va_end     <= 10'd251;
                        vs_sta     <= 10'd256;
                        vs_end     <= 10'd258;
                    end else begin
                        max_height <= 10'd525;  // 526 lines
                        va_end     <= 10'd502;
                        vs_sta     <= 10'd512;
                        vs_end     <= 10'd515;
                    end
                end
                scan_pkg::CHIP_6567R56A: begin
                    // 1024 dots per doubled line
                    max_width <= 11'd1023;
                    hs_sta    <= 11'd20;
                    hs_end    <= 11'd142;  // sync pulse 122
                    ha_sta    <= 11'd204;  // front porch 62
                    hoffset   <= 11'd20;
                    voffset   <= 10'd52;
                    if (is_15khz) begin
                        max_height <= 10'd261;  // 262 lines
                        va_end     <= 10'd251;
                        vs_sta     <= 10'd256;
                        vs_end     <= 10'd258;
                    end else begin
                        max_height <= 10'd523;  // 524 lines
                        va_end     <= 10'd502;
                        vs_sta     <= 10'd512;
                        vs_end     <= 10'd515;
                    end
                end
            endcase
        end
        // otherwise hold, geometry only changes through reset
    end

endmodule

// ==== tb_hires_scan.sv ====
`timescale 1ns/1ps

`include "scan_defs.svh"

module tb_hires_scan;

    // expected run length per test in clock cycles with resets included
    localparam int len_hsync  = 2 * (21 * 1008 + 200) + 1060 + 1044 + 128;
    localparam int len_slow   = 2 * (21 * 1008 + 200) + 32;
    localparam int len_frame  = 263 * 2048 + 32;  // one 15 khz frame of 6567R56A
    localparam int len_resync = 52 * 1040 + 32;
    localparam int len_double = 4 * 1024 + 32;
    localparam int cycle_limit =
        (len_hsync + len_slow + len_frame + len_resync + len_double) * 11 / 10;

    logic                 clk_dot4x;
    logic                 rst;
    scan_pkg::chip_t      chip;
    logic                 is_15khz;
    logic [`SCAN_RXW-1:0] raster_x;
    scan_pkg::hpos_t      hires_raster_x;
    logic [`SCAN_RYW-1:0] raster_y;
    scan_pkg::color_t     pixel_color3;
    logic                 hsync;
    logic                 vsync;
    logic                 active;
    scan_pkg::color_t     pixel_color4;
    logic                 half_bright;

    int               error_count;
    int               check_count;
    int               cycle_count;     // posedges since time zero
    logic [15:0]      lfsr_state;
    scan_pkg::color_t line_colors [2048];  // what was written into the line buffer

    // own copy of the geometry for the chip under test
    int ref_width;
    int ref_hs_sta;
    int ref_hs_end;
    int ref_ha_sta;
    int ref_hoffset;
    int ref_height;
    int ref_vs_sta;
    int ref_vs_end;
    int ref_va_end;
    int ref_voffset;

    hires_scan_top UUT (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip           (chip),
        .is_15khz       (is_15khz),
        .raster_x       (raster_x),
        .hires_raster_x (hires_raster_x),
        .raster_y       (raster_y),
        .pixel_color3   (pixel_color3),
        .hsync          (hsync),
        .vsync          (vsync),
        .active         (active),
        .pixel_color4   (pixel_color4),
        .half_bright    (half_bright)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #10 clk_dot4x = ~clk_dot4x;  // 50 mhz
    end

    always @(posedge clk_dot4x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, no result after %0d cycles, %0d checks, %0d errors",
                     cycle_count, check_count, error_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic next_cycle;
        @(posedge clk_dot4x);
        #2;  // drive and sample clear of the edge
    endtask

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("at %0t: %s", $time, what);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_color(output scan_pkg::color_t c);
        int i;
        for (i = 0; i < `SCAN_CW; i++) begin
            c[i]       = lfsr_state[15];  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // cycles after reset release until the counter has taken n steps
    function automatic int cycles_for(input int n, input logic slow);
        if (slow) begin
            cycles_for = 2 * n - 1;  // first step lands on the first edge and then every other
        end else begin
            cycles_for = n;
        end
    endfunction

    task automatic load_reference_geometry(input logic [1:0] code, input logic slow);
        ref_hs_sta = 20;
        case (code)
            `SCAN_CHIP_6567R8: begin
                ref_width   = 1039;
                ref_hs_end  = 144;
                ref_ha_sta  = 206;
                ref_hoffset = 20;
                ref_voffset = 52;
                ref_height  = slow ? 262 : 525;
                ref_va_end  = slow ? 251 : 502;
                ref_vs_sta  = slow ? 256 : 512;
                ref_vs_end  = slow ? 258 : 515;
            end
            `SCAN_CHIP_6567R56A: begin
                ref_width   = 1023;
                ref_hs_end  = 142;
                ref_ha_sta  = 204;
                ref_hoffset = 20;
                ref_voffset = 52;
                ref_height  = slow ? 261 : 523;
                ref_va_end  = slow ? 251 : 502;
                ref_vs_sta  = slow ? 256 : 512;
                ref_vs_end  = slow ? 258 : 515;
            end
            default: begin  // 6569 R1 and R5 alike
                ref_width   = 1007;
                ref_hs_end  = 140;
                ref_ha_sta  = 200;
                ref_hoffset = 10;
                ref_voffset = 20;
                ref_height  = slow ? 311 : 623;
                ref_va_end  = slow ? 285 : 569;
                ref_vs_sta  = slow ? 290 : 580;
                ref_vs_end  = slow ? 292 : 583;
            end
        endcase
    endtask

    task automatic apply_reset(input logic [1:0] code, input logic slow);
        load_reference_geometry(code, slow);
        rst            = 1'b1;
        chip           = scan_pkg::chip_t'(code);
        is_15khz       = slow;
        raster_x       = 'd1;  // clear of line start and frame start
        raster_y       = 'd1;
        hires_raster_x = '1;   // top address lies outside every read window
        pixel_color3   = '0;
        repeat (16) next_cycle();
        rst = 1'b0;
    endtask

    // hsync edges, line period and first active pixel counted from reset release
    task automatic measure_line_timing(input logic [1:0] code, input logic slow);
        int   k;
        int   fall1;
        int   fall2;
        int   rise1;
        int   first_active;
        int   active_at;
        int   stop_at;
        logic prev_hs;
        apply_reset(code, slow);
        k            = 0;
        fall1        = -1;
        fall2        = -1;
        rise1        = -1;
        first_active = -1;
        if (ref_height - ref_voffset < ref_va_end) begin
            active_at = cycles_for(ref_ha_sta, slow);  // reset line already visible
        end else begin
            active_at = cycles_for((ref_voffset + 1) * (ref_width + 1) + ref_ha_sta, slow);
        end
        stop_at = cycles_for(ref_hs_sta + ref_width + 1, slow);  // second hsync fall
        if (active_at > stop_at) begin
            stop_at = active_at;
        end
        prev_hs = hsync;
        check_value("active", 0, active);
        while ((first_active < 0 || fall2 < 0) && k < stop_at + 16) begin
            next_cycle();
            k++;
            if (prev_hs && !hsync) begin
                if (fall1 < 0) begin
                    fall1 = k;
                end else if (fall2 < 0) begin
                    fall2 = k;
                end
            end
            if (!prev_hs && hsync && rise1 < 0) begin
                rise1 = k;
            end
            if (active && first_active < 0) begin
                first_active = k;  // first visible pixel
            end
            prev_hs = hsync;
        end
        if (fall2 < 0 || rise1 < 0) begin
            report_failure("hsync did not toggle twice after reset release");
        end else begin
            check_value("hsync fall cycle", cycles_for(ref_hs_sta, slow), fall1);
            check_value("hsync rise cycle", cycles_for(ref_hs_end, slow), rise1);
            check_value("hsync line period", (slow ? 2 : 1) * (ref_width + 1), fall2 - fall1);
        end
        check_value("active first cycle", active_at, first_active);
    endtask

    // one 15 khz frame sampled once per line at its hsync fall
    task automatic verify_vsync_and_dimming;
        int   line;
        int   v;
        int   low_lines;
        int   first_low;
        logic hb_expected;
        logic prev_hs;
        apply_reset(`SCAN_CHIP_6567R56A, 1'b1);
        line        = 0;
        v           = ref_height - ref_voffset;  // v_count at release
        low_lines   = 0;
        first_low   = -1;
        hb_expected = 1'b0;
        prev_hs     = hsync;
        while (line <= ref_height) begin
            next_cycle();
            if (prev_hs && !hsync) begin
                check_value("half_bright", hb_expected, half_bright);
                if (!vsync) begin
                    low_lines++;
                    if (first_low < 0) begin
                        first_low = line;
                    end
                end
                if (v == ref_height) begin
                    v           = 0;
                    hb_expected = 1'b0;  // bright again after the wrap
                end else begin
                    v++;
                    hb_expected = !hb_expected;
                end
                line++;
            end
            prev_hs = hsync;
        end
        check_value("vsync first low line", ref_vs_sta - (ref_height - ref_voffset), first_low);
        check_value("vsync low lines", ref_vs_end - ref_vs_sta, low_lines);
    endtask

    task automatic exercise_frame_resync;
        int   falls;
        logic prev_hs;
        logic prev_vs;
        logic seen;
        apply_reset(`SCAN_CHIP_6567R8, 1'b0);
        falls   = 0;
        prev_hs = hsync;
        while (falls < 10) begin  // let the frame move on a bit
            next_cycle();
            if (prev_hs && !hsync) begin
                falls++;
            end
            prev_hs = hsync;
        end
        repeat (300) next_cycle();  // mid line and well past hsync
        raster_x = '0;
        raster_y = '0;
        next_cycle();
        raster_x = 'd1;
        raster_y = 'd1;
        check_value("vsync", 1, vsync);
        falls   = 0;
        seen    = 1'b0;
        prev_hs = hsync;
        prev_vs = vsync;
        while (!seen && falls <= ref_height) begin
            next_cycle();
            if (prev_vs && !vsync) begin
                seen = 1'b1;
            end else if (prev_hs && !hsync) begin
                falls++;
            end
            prev_hs = hsync;
            prev_vs = vsync;
        end
        if (!seen) begin
            report_failure("vsync never fell after the frame resync");
        end else begin
            // vsync falls at h_count 0 before that line reaches its own hsync
            check_value("vsync lines after resync", ref_vs_sta - (ref_height - ref_voffset),
                        falls + 1);
        end
    endtask

    task automatic replay_doubled_line;
        int               release_at;
        int               a;
        int               k;
        int               h_addr;
        int               h_reg;
        scan_pkg::color_t c;
        scan_pkg::color_t expected;
        apply_reset(`SCAN_CHIP_6567R56A, 1'b0);
        release_at = cycle_count;
        raster_x   = '0;  // exactly one dot_phase hit within four cycles
        repeat (4) next_cycle();
        raster_x = 'd1;
        for (a = 0; a < 1024; a++) begin
            draw_color(c);
            line_colors[a] = c;
            hires_raster_x = scan_pkg::hpos_t'(a);
            pixel_color3   = c;
            next_cycle();
        end
        hires_raster_x = '1;
        raster_x       = '0;  // filled buffer turns into the read side
        repeat (4) next_cycle();
        raster_x = 'd1;
        while ((cycle_count - release_at) % (ref_width + 1) != ref_hoffset) begin
            next_cycle();
        end
        next_cycle();
        expected = '0;
        for (a = 0; a <= ref_width - ref_hoffset; a++) begin
            next_cycle();
            k      = cycle_count - release_at;
            h_addr = (k - 2) % (ref_width + 1);  // h_count that addressed the RAM
            h_reg  = (k - 1) % (ref_width + 1);  // h_count seen by the output register
            if (h_reg >= ref_hoffset) begin
                expected = line_colors[h_addr - ref_hoffset];
            end
            check_value("pixel_color4", expected, pixel_color4);
        end
    endtask

    initial begin
        error_count    = 0;
        check_count    = 0;
        cycle_count    = 0;
        lfsr_state     = 16'd9112;
        rst            = 1'b1;
        chip           = scan_pkg::CHIP_6569R1;
        is_15khz       = 1'b0;
        raster_x       = 'd1;
        raster_y       = 'd1;
        hires_raster_x = '1;
        pixel_color3   = '0;

        measure_line_timing(`SCAN_CHIP_6569R1, 1'b0);
        measure_line_timing(`SCAN_CHIP_6569R5, 1'b0);
        measure_line_timing(`SCAN_CHIP_6567R8, 1'b0);
        measure_line_timing(`SCAN_CHIP_6567R56A, 1'b0);
        measure_line_timing(`SCAN_CHIP_6569R1, 1'b1);  // counters step every other cycle
        verify_vsync_and_dimming();
        exercise_frame_resync();
        replay_doubled_line();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
